//--- source/leaf_pkg.sv
package leaf_pkg;

    // packet geometry on the tree links.
    localparam int PACKET_BITS   = 49;
    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_ADDR_BITS = 7;

    localparam int NUM_IN_PORTS   = 5;
    localparam int FIFO_DEPTH     = 8;
    localparam int OUT_FIFO_DEPTH = 4;

    // register byte offsets.
    localparam logic [7:0] REG_CTRL    = 8'h00;
    localparam logic [7:0] REG_LEAF_ID = 8'h04;
    localparam logic [7:0] REG_DEST    = 8'h08;
    localparam logic [7:0] REG_DROPS   = 8'h0C;
    localparam logic [7:0] REG_RESULTS = 8'h10;

    typedef logic [PAYLOAD_BITS-1:0] word_t;

    // vld sits in the top bit, payload in the low 32.
    typedef struct packed {
        logic                     vld;
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
        logic [NUM_ADDR_BITS-1:0] addr;
        word_t                    payload;
    } packet_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

//--- source/leaf_port_fifo.sv
module leaf_port_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t wdata,
    output logic     full,
    input  logic     pop,
    output payload_t rdata,
    output logic     empty
);

    // depth is a power of two; the extra pointer bit tells full from empty.
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t            mem [DEPTH];
    logic [PTR_BITS:0]   wr_ptr;
    logic [PTR_BITS:0]   rd_ptr;
    logic                do_push;
    logic                do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_BITS] != rd_ptr[PTR_BITS]) &&
                   (wr_ptr[PTR_BITS-1:0] == rd_ptr[PTR_BITS-1:0]);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head entry is visible before the pop.
    assign rdata = mem[rd_ptr[PTR_BITS-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[PTR_BITS-1:0]] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

//--- source/leaf_packet_router.sv
module leaf_packet_router (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  leaf_pkg::packet_t                    din_leaf,
    input  logic [leaf_pkg::NUM_LEAF_BITS-1:0]   leaf_id,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]    fifo_full,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]    fifo_push,
    output leaf_pkg::word_t                      fifo_wdata,
    output logic                                 drop
);

    import leaf_pkg::*;

    logic                    leaf_hit;
    logic [NUM_IN_PORTS-1:0] port_sel;
    logic                    stored;

    assign leaf_hit = din_leaf.vld && (din_leaf.leaf == leaf_id);

    // one-hot port decode that leaves out-of-range ports unselected.
    always_comb begin
        port_sel = '0;
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            port_sel[i] = (din_leaf.port == NUM_PORT_BITS'(i));
        end
    end

    // written at the arrival edge with no back-pressure upstream.
    assign fifo_push  = leaf_hit ? (port_sel & ~fifo_full) : '0;
    assign fifo_wdata = din_leaf.payload;
    assign stored     = |fifo_push;

    // wrong leaf, bad port or full queue.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drop <= 1'b0;
        end else begin
            drop <= din_leaf.vld && !stored;
        end
    end

endmodule

//--- source/leaf_sum_kernel.sv
module leaf_sum_kernel (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              start,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0] fifo_empty,
    input  leaf_pkg::word_t                   fifo_rdata [leaf_pkg::NUM_IN_PORTS],
    output logic [leaf_pkg::NUM_IN_PORTS-1:0] fifo_pop,
    output logic                              sum_push,
    output leaf_pkg::word_t                   sum,
    input  logic                              sum_full
);

    import leaf_pkg::*;

    logic  fire;
    word_t pair_lo;
    word_t pair_hi;
    word_t total;

    // all queues hold a word and the packetizer has room.
    assign fire     = start && !(|fifo_empty) && !sum_full;
    assign fifo_pop = {NUM_IN_PORTS{fire}};

    // pairs first and then the odd port.
    always_comb begin
        pair_lo = fifo_rdata[0] + fifo_rdata[1];
        pair_hi = fifo_rdata[2] + fifo_rdata[3];
        total   = pair_lo + pair_hi;
        for (int i = 4; i < NUM_IN_PORTS; i++) begin
            total = total + fifo_rdata[i];
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            sum <= total;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_push <= 1'b0;
        end else begin
            sum_push <= fire;
        end
    end

endmodule

//--- source/leaf_packetizer.sv
module leaf_packetizer (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               sum_push,
    input  leaf_pkg::word_t                    sum,
    input  logic [leaf_pkg::NUM_LEAF_BITS-1:0] dest_leaf,
    input  logic [leaf_pkg::NUM_PORT_BITS-1:0] dest_port,
    output logic                               full,
    output leaf_pkg::packet_t                  dout,
    input  logic                               dout_ready,
    output logic                               result
);

    import leaf_pkg::*;

    packet_t                          pkt_in;
    packet_t                          head;
    logic                             fifo_full;
    logic                             fifo_empty;
    logic                             take;
    logic                             accepted;
    logic [NUM_ADDR_BITS-1:0]         seq;
    logic [$clog2(OUT_FIFO_DEPTH):0]  level;

    always_comb begin
        pkt_in.vld     = 1'b1;
        pkt_in.leaf    = dest_leaf;
        pkt_in.port    = dest_port;
        pkt_in.addr    = seq;
        pkt_in.payload = sum;
    end

    leaf_port_fifo #(
        .payload_t (packet_t),
        .DEPTH     (OUT_FIFO_DEPTH)
    ) out_fifo_i (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (sum_push),
        .wdata  (pkt_in),
        .full   (fifo_full),
        .pop    (take),
        .rdata  (head),
        .empty  (fifo_empty)
    );

    assign accepted = sum_push && !fifo_full;
    assign take     = !fifo_empty && dout_ready;
    assign result   = take;
    assign dout     = fifo_empty ? '0 : head;

    // keep one slot free for the sum already in the adder register.
    assign full = fifo_full ||
                  (sum_push && (level == ($bits(level))'(OUT_FIFO_DEPTH - 1)));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            level <= '0;
        end else begin
            case ({accepted, take})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // wraps at 128.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seq <= '0;
        end else if (accepted) begin
            seq <= seq + 1'b1;
        end
    end

endmodule

//--- source/leaf_apb_regs.sv
module leaf_apb_regs (
    input  logic                               clk,
    input  logic                               arst_n,
    input  leaf_pkg::apb_req_t                 apb_req,
    output leaf_pkg::apb_rsp_t                 apb_rsp,
    input  logic                               drop,
    input  logic                               result,
    output logic                               start,
    output logic [leaf_pkg::NUM_LEAF_BITS-1:0] leaf_id,
    output logic [leaf_pkg::NUM_LEAF_BITS-1:0] dest_leaf,
    output logic [leaf_pkg::NUM_PORT_BITS-1:0] dest_port
);

    import leaf_pkg::*;

    logic        access;
    logic        mapped;
    logic        read_only;
    logic        wr_en;
    logic [31:0] rdata;
    logic [31:0] drops_q;
    logic [31:0] results_q;

    // second cycle of the transfer.
    assign access = apb_req.psel && apb_req.penable;

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        rdata     = '0;
        case (apb_req.paddr)
            REG_CTRL: begin
                rdata[0] = start;
            end
            REG_LEAF_ID: begin
                rdata[NUM_LEAF_BITS-1:0] = leaf_id;
            end
            REG_DEST: begin
                rdata[NUM_LEAF_BITS-1:0]  = dest_leaf;
                rdata[8 +: NUM_PORT_BITS] = dest_port;
            end
            REG_DROPS: begin
                rdata     = drops_q;
                read_only = 1'b1;
            end
            REG_RESULTS: begin
                rdata     = results_q;
                read_only = 1'b1;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    assign wr_en = access && apb_req.pwrite && mapped && !read_only;

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && read_only));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start     <= 1'b0;
            leaf_id   <= '0;
            dest_leaf <= '0;
            dest_port <= '0;
        end else if (wr_en) begin
            case (apb_req.paddr)
                REG_CTRL:    start   <= apb_req.pwdata[0];
                REG_LEAF_ID: leaf_id <= apb_req.pwdata[NUM_LEAF_BITS-1:0];
                REG_DEST: begin
                    dest_leaf <= apb_req.pwdata[NUM_LEAF_BITS-1:0];
                    dest_port <= apb_req.pwdata[8 +: NUM_PORT_BITS];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drops_q   <= '0;
            results_q <= '0;
        end else begin
            drops_q   <= drops_q + 32'(drop);
            results_q <= results_q + 32'(result);
        end
    end

endmodule

//--- source/leaf_top.sv
module leaf_top (
    input  logic               clk,
    input  logic               arst_n,
    input  leaf_pkg::packet_t  din_leaf,
    output leaf_pkg::packet_t  dout_leaf,
    input  logic               dout_ready,
    input  logic               resend,
    input  leaf_pkg::apb_req_t apb_req,
    output leaf_pkg::apb_rsp_t apb_rsp
);

    import leaf_pkg::*;

    logic [NUM_IN_PORTS-1:0]  fifo_push;
    logic [NUM_IN_PORTS-1:0]  fifo_full;
    logic [NUM_IN_PORTS-1:0]  fifo_pop;
    logic [NUM_IN_PORTS-1:0]  fifo_empty;
    word_t                    fifo_wdata;
    word_t                    fifo_rdata [NUM_IN_PORTS];
    logic                     drop;
    logic                     result;
    logic                     start;
    logic [NUM_LEAF_BITS-1:0] leaf_id;
    logic [NUM_LEAF_BITS-1:0] dest_leaf;
    logic [NUM_PORT_BITS-1:0] dest_port;
    logic                     sum_push;
    logic                     sum_full;
    word_t                    sum;
    packet_t                  pkt_out;
    logic                     out_ready;

    leaf_packet_router router_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .din_leaf   (din_leaf),
        .leaf_id    (leaf_id),
        .fifo_full  (fifo_full),
        .fifo_push  (fifo_push),
        .fifo_wdata (fifo_wdata),
        .drop       (drop)
    );

    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_port
        leaf_port_fifo #(
            .payload_t (word_t),
            .DEPTH     (FIFO_DEPTH)
        ) port_fifo_i (
            .clk    (clk),
            .arst_n (arst_n),
            .push   (fifo_push[i]),
            .wdata  (fifo_wdata),
            .full   (fifo_full[i]),
            .pop    (fifo_pop[i]),
            .rdata  (fifo_rdata[i]),
            .empty  (fifo_empty[i])
        );
    end

    leaf_sum_kernel kernel_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .fifo_empty (fifo_empty),
        .fifo_rdata (fifo_rdata),
        .fifo_pop   (fifo_pop),
        .sum_push   (sum_push),
        .sum        (sum),
        .sum_full   (sum_full)
    );

    leaf_packetizer packetizer_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .sum_push   (sum_push),
        .sum        (sum),
        .dest_leaf  (dest_leaf),
        .dest_port  (dest_port),
        .full       (sum_full),
        .dout       (pkt_out),
        .dout_ready (out_ready),
        .result     (result)
    );

    leaf_apb_regs regs_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .drop      (drop),
        .result    (result),
        .start     (start),
        .leaf_id   (leaf_id),
        .dest_leaf (dest_leaf),
        .dest_port (dest_port)
    );

    // resend blanks the link and holds the head packet.
    assign out_ready = dout_ready && !resend;
    assign dout_leaf = resend ? '0 : pkt_out;

endmodule

//--- dv/leaf_properties.sv
module leaf_properties (
    input  logic                               clk,
    input  logic                               arst_n,
    input  leaf_pkg::packet_t                  dout_leaf,
    input  logic                               dout_ready,
    input  logic                               resend,
    input  logic [leaf_pkg::NUM_LEAF_BITS-1:0] dest_leaf,
    input  logic [leaf_pkg::NUM_PORT_BITS-1:0] dest_port,
    input  leaf_pkg::apb_req_t                 apb_req,
    input  leaf_pkg::apb_rsp_t                 apb_rsp
);

    import leaf_pkg::*;

    int unsigned              fail_count;
    logic [NUM_ADDR_BITS-1:0] next_addr;
    logic                     access;
    logic                     mapped;
    logic                     counter_reg;
    logic                     bad_access;

    initial fail_count = 0;

    assign access      = apb_req.psel && apb_req.penable;
    assign counter_reg = (apb_req.paddr == REG_DROPS) || (apb_req.paddr == REG_RESULTS);
    assign mapped      = counter_reg || (apb_req.paddr == REG_CTRL) ||
                         (apb_req.paddr == REG_LEAF_ID) || (apb_req.paddr == REG_DEST);
    assign bad_access  = !mapped || (apb_req.pwrite && counter_reg);

    // sequence number of the next packet to leave.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            next_addr <= '0;
        end else if (dout_leaf.vld && dout_ready) begin
            next_addr <= next_addr + 1'b1;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (dout_leaf.vld && !dout_ready && !resend) |=> (resend || $stable(dout_leaf)))
    else begin
        $error("offered packet changed while stalled");
        fail_count++;
    end

    a_resend_blank: assert property (@(posedge clk) disable iff (!arst_n)
        resend |-> (dout_leaf == '0))
    else begin
        $error("packet bus not blank during resend");
        fail_count++;
    end

    a_dest: assert property (@(posedge clk) disable iff (!arst_n)
        dout_leaf.vld |-> ((dout_leaf.leaf == dest_leaf) && (dout_leaf.port == dest_port)))
    else begin
        $error("packet destination differs from the programmed one");
        fail_count++;
    end

    a_seq: assert property (@(posedge clk) disable iff (!arst_n)
        dout_leaf.vld |-> (dout_leaf.addr == next_addr))
    else begin
        $error("packet addr field out of sequence");
        fail_count++;
    end

    a_slverr: assert property (@(posedge clk) disable iff (!arst_n)
        access |-> (apb_rsp.pready && (apb_rsp.pslverr == bad_access)))
    else begin
        $error("wrong apb response");
        fail_count++;
    end

endmodule

//--- dv/leaf_tb.sv
module leaf_tb;

    import leaf_pkg::*;

    localparam int         PERIOD       = 100;
    localparam int         RESET_CYCLES = 8;
    localparam int         PRE_SETS     = 3;
    localparam int         RUN_SETS     = 140;
    localparam int         FILL_SETS    = 8;
    localparam int         OVERFLOW     = 3;
    // bad packets stay under a quarter of the sets.
    localparam int         TOTAL_WORDS  = NUM_IN_PORTS * (PRE_SETS + RUN_SETS + FILL_SETS) +
                                          OVERFLOW + RUN_SETS / 4;
    localparam int         STALL_LEN    = 4096;
    localparam logic [4:0] MY_LEAF      = 5'h0B;
    localparam logic [4:0] DEST_LEAF    = 5'h13;
    localparam logic [3:0] DEST_PORT    = 4'h2;
    localparam word_t      DEST_WORD    = (32'(DEST_PORT) << 8) | 32'(DEST_LEAF);

    logic     clk;
    logic     arst_n;
    packet_t  din_leaf;
    packet_t  dout_leaf;
    logic     dout_ready;
    logic     resend;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    word_t       port_q [NUM_IN_PORTS][$];
    word_t       exp_q [$];
    logic [3:0]  stall_pat [STALL_LEN];
    logic        hold_ready;
    int unsigned exp_drops;
    int unsigned exp_sums;
    int unsigned transfers;

    leaf_top dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .din_leaf   (din_leaf),
        .dout_leaf  (dout_leaf),
        .dout_ready (dout_ready),
        .resend     (resend),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp)
    );

    bind leaf_top leaf_properties props_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .dout_leaf  (dout_leaf),
        .dout_ready (dout_ready),
        .resend     (resend),
        .dest_leaf  (dest_leaf),
        .dest_port  (dest_port),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp)
    );

    task automatic fail_value(input string test, input word_t expected, input word_t actual);
        $display("Fail %s: expected %h, actual %h", test, expected, actual);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_plain(input string what);
        $display("Error: %s", what);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string test, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            fail_value(test, expected, actual);
        end
    endtask

    // called at the drive point and returns there.
    task automatic apb_access(input logic write, input logic [7:0] addr, input word_t wdata,
                              output word_t rdata, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #10;
        apb_req.penable = 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #10;
        apb_req = '0;
    endtask

    task automatic apb_write(input string test, input logic [7:0] addr, input word_t wdata,
                             input logic exp_err);
        word_t rdata;
        logic  err;
        apb_access(1'b1, addr, wdata, rdata, err);
        check_value(test, word_t'(exp_err), word_t'(err));
    endtask

    task automatic apb_read(input string test, input logic [7:0] addr, input word_t expected,
                            input logic exp_err);
        word_t rdata;
        logic  err;
        apb_access(1'b0, addr, '0, rdata, err);
        check_value(test, word_t'(exp_err), word_t'(err));
        if (!exp_err) begin
            check_value(test, expected, rdata);
        end
    endtask

    // one full set of port words gives one expected sum.
    task automatic collect_sum();
        word_t total;
        logic  complete;
        complete = 1'b1;
        for (int p = 0; p < NUM_IN_PORTS; p++) begin
            if (port_q[p].size() == 0) begin
                complete = 1'b0;
            end
        end
        if (complete) begin
            total = '0;
            for (int p = 0; p < NUM_IN_PORTS; p++) begin
                total = total + port_q[p].pop_front();
            end
            exp_q.push_back(total);
            exp_sums++;
        end
    endtask

    task automatic send_packet(input logic [4:0] leaf, input logic [3:0] port,
                               input word_t payload, input logic stored);
        din_leaf.vld     = 1'b1;
        din_leaf.leaf    = leaf;
        din_leaf.port    = port;
        din_leaf.addr    = '0;
        din_leaf.payload = payload;
        if (stored) begin
            port_q[port].push_back(payload);
            collect_sum();
        end else begin
            exp_drops++;
        end
        @(posedge clk);
        #10;
        din_leaf = '0;
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #10;
            n++;
            if (n > max_cycles) begin
                fail_plain("expected sums did not leave the leaf in time");
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ready and resend follow a stored random pattern unless held.
    initial begin
        int unsigned cyc;
        cyc        = 0;
        dout_ready = 1'b0;
        resend     = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            if (hold_ready) begin
                dout_ready = 1'b0;
                resend     = 1'b0;
            end else begin
                dout_ready = (stall_pat[cyc % STALL_LEN] > 4'd3);
                resend     = (stall_pat[cyc % STALL_LEN] == 4'hF);
            end
            cyc++;
        end
    end

    always @(negedge clk) begin
        word_t expected;
        if (arst_n && dout_leaf.vld && dout_ready) begin
            transfers++;
            if (exp_q.size() == 0) begin
                fail_plain("packet left the leaf with no sum expected");
            end
            expected = exp_q.pop_front();
            check_value("sum", expected, dout_leaf.payload);
        end
        if (dut_i.props_i.fail_count != 0) begin
            fail_plain("an assertion on the leaf failed");
        end
    end

    initial begin
        #(PERIOD * (RESET_CYCLES + 4 * TOTAL_WORDS + 400));
        fail_plain("watchdog timeout, the run did not finish");
    end

    initial begin
        void'($urandom(32'hb74a8504));
        for (int i = 0; i < STALL_LEN; i++) begin
            stall_pat[i] = 4'($urandom);
        end
        arst_n     = 1'b0;
        din_leaf   = '0;
        apb_req    = '0;
        hold_ready = 1'b1;
        exp_drops  = 0;
        exp_sums   = 0;
        transfers  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        arst_n = 1'b1;
        @(posedge clk);
        #10;

        apb_write("cfg_id", REG_LEAF_ID, 32'(MY_LEAF), 1'b0);
        apb_write("cfg_dest", REG_DEST, DEST_WORD, 1'b0);
        hold_ready = 1'b0;

        // start is still 0 so nothing may leave.
        for (int s = 0; s < PRE_SETS; s++) begin
            for (int p = 0; p < NUM_IN_PORTS; p++) begin
                send_packet(MY_LEAF, 4'(p), $urandom, 1'b1);
            end
        end
        send_packet(MY_LEAF ^ 5'h04, 4'd1, $urandom, 1'b0);
        send_packet(MY_LEAF, 4'd9, $urandom, 1'b0);
        repeat (20) @(posedge clk);
        #10;
        check_value("start_off", 0, transfers);
        apb_read("results_idle", REG_RESULTS, 0, 1'b0);
        apb_write("start", REG_CTRL, 32'h1, 1'b0);
        wait_drain(200);

        for (int s = 0; s < RUN_SETS; s++) begin
            for (int p = 0; p < NUM_IN_PORTS; p++) begin
                send_packet(MY_LEAF, 4'(p), $urandom, 1'b1);
            end
            if (s % 7 == 0) begin
                send_packet(MY_LEAF + 5'(1 + $urandom % 31), 4'($urandom % 5), $urandom, 1'b0);
            end
            if (s % 11 == 3) begin
                send_packet(MY_LEAF, 4'(5 + $urandom % 11), $urandom, 1'b0);
            end
        end
        wait_drain(2000);

        // port 0 alone cannot fire the kernel, so its queue overflows.
        hold_ready = 1'b1;
        @(posedge clk);
        #10;
        for (int i = 0; i < FILL_SETS + OVERFLOW; i++) begin
            send_packet(MY_LEAF, 4'd0, $urandom, i < FILL_SETS);
        end
        for (int p = 1; p < NUM_IN_PORTS; p++) begin
            for (int i = 0; i < FILL_SETS; i++) begin
                send_packet(MY_LEAF, 4'(p), $urandom, 1'b1);
            end
        end
        repeat (10) @(posedge clk);
        #10;
        hold_ready = 1'b0;
        wait_drain(400);
        repeat (4) @(posedge clk);
        #10;

        apb_read("drops", REG_DROPS, exp_drops, 1'b0);
        apb_read("results", REG_RESULTS, exp_sums, 1'b0);
        apb_read("dest", REG_DEST, DEST_WORD, 1'b0);
        apb_read("unmapped_read", 8'h14, '0, 1'b1);
        apb_write("unmapped_write", 8'h20, 32'h5, 1'b1);
        apb_write("drops_write", REG_DROPS, 32'hFFFF_FFFF, 1'b1);
        apb_write("results_write", REG_RESULTS, 32'h0, 1'b1);
        apb_read("drops_kept", REG_DROPS, exp_drops, 1'b0);
        apb_read("results_kept", REG_RESULTS, exp_sums, 1'b0);

        if (dut_i.props_i.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "assertion failures on the leaf");
        end
    end

endmodule

//--- sources.f
source/leaf_pkg.sv
source/leaf_port_fifo.sv
source/leaf_packet_router.sv
source/leaf_sum_kernel.sv
source/leaf_packetizer.sv
source/leaf_apb_regs.sv
source/leaf_top.sv
dv/leaf_properties.sv
dv/leaf_tb.sv

//--- Bender.yml
package:
  name: leaf

sources:
  - source/leaf_pkg.sv
  - source/leaf_port_fifo.sv
  - source/leaf_packet_router.sv
  - source/leaf_sum_kernel.sv
  - source/leaf_packetizer.sv
  - source/leaf_apb_regs.sv
  - source/leaf_top.sv
  - target: dv
    files:
      - dv/leaf_properties.sv
      - dv/leaf_tb.sv
